// ==== bench/cutoff_tb.sv ====
// Runs from the project root; vector records are applied in file order, one message in flight.
`timescale 1ns/1ps

module cutoff_tb;

    logic                                 clk;
    logic                                 rstn;
    logic [cutoff_pkg::num_creators-1:0]  creator_tvalid;
    logic [cutoff_pkg::num_creators-1:0]  creator_tready;
    cutoff_pkg::word_t                    creator_tdata [cutoff_pkg::num_creators];
    logic [cutoff_pkg::num_creators-1:0]  creator_tlast;
    logic                                 deps_full;
    logic                                 release_valid;
    cutoff_pkg::word_t                    release_parent;
    logic                                 sched_tvalid;
    logic                                 sched_tready;
    cutoff_pkg::word_t                    sched_tdata;
    logic                                 sched_tlast;
    cutoff_pkg::acc_id_t                  sched_tid;
    logic                                 deps_tvalid;
    logic                                 deps_tready;
    cutoff_pkg::word_t                    deps_tdata;
    logic                                 deps_tlast;
    logic                                 ack_tvalid;
    logic                                 ack_tready;
    cutoff_pkg::word_t                    ack_tdata;
    cutoff_pkg::acc_id_t                  ack_tdest;

    logic [64:0]                          creator_q [cutoff_pkg::num_creators][$]; // {last, data}.
    logic [cutoff_pkg::num_creators-1:0]  taken;
    cutoff_pkg::word_t                    sched_data_q [$];
    logic                                 sched_last_q [$];
    cutoff_pkg::acc_id_t                  sched_tid_q [$];
    cutoff_pkg::word_t                    deps_data_q [$];
    logic                                 deps_last_q [$];
    cutoff_pkg::acc_id_t                  ack_dest_q [$];
    cutoff_pkg::ack_code_t                ack_code_q [$];
    string                                records [$];
    string                                cur_test = "none";
    int                                   errors = 0;
    int                                   n_records = 0;

    tb_clock #(.period(100)) clock_i (.clk);

    cutoff_top dut_i (.clk, .rstn, .creator_tvalid, .creator_tready, .creator_tdata,
        .creator_tlast, .deps_full, .release_valid, .release_parent,
        .sched_tvalid, .sched_tready, .sched_tdata, .sched_tlast, .sched_tid,
        .deps_tvalid, .deps_tready, .deps_tdata, .deps_tlast,
        .ack_tvalid, .ack_tready, .ack_tdata, .ack_tdest);

    task automatic compare_field(string what, logic [63:0] exp, logic [63:0] act);
        if (exp !== act) begin
            $display("ERROR %s %s expected %h actual %h", cur_test, what, exp, act);
            errors++;
        end
    endtask

    // Handshakes seen here complete at the next rising edge.
    task automatic sample_outputs();
        for (int i = 0; i < cutoff_pkg::num_creators; i++) begin
            taken[i] = creator_tvalid[i] && creator_tready[i];
        end
        if (sched_tvalid && sched_tready) begin
            if (sched_data_q.size() == 0) begin
                $display("%s: unexpected scheduler word %h", cur_test, sched_tdata);
                errors++;
            end else begin
                compare_field("sched_tdata", sched_data_q.pop_front(), sched_tdata);
                compare_field("sched_tlast", 64'(sched_last_q.pop_front()), 64'(sched_tlast));
                compare_field("sched_tid", 64'(sched_tid_q.pop_front()), 64'(sched_tid));
            end
        end
        if (deps_tvalid && deps_tready) begin
            if (deps_data_q.size() == 0) begin
                $display("%s: unexpected dependence word %h", cur_test, deps_tdata);
                errors++;
            end else begin
                compare_field("deps_tdata", deps_data_q.pop_front(), deps_tdata);
                compare_field("deps_tlast", 64'(deps_last_q.pop_front()), 64'(deps_tlast));
            end
        end
        if (ack_tvalid && ack_tready) begin
            if (ack_dest_q.size() == 0) begin
                $display("%s: unexpected ack %h to creator %0d", cur_test, ack_tdata, ack_tdest);
                errors++;
            end else begin
                compare_field("ack_tdest", 64'(ack_dest_q.pop_front()), 64'(ack_tdest));
                compare_field("ack_tdata", {56'd0, ack_code_q.pop_front()}, ack_tdata);
            end
        end
    endtask

    task automatic update_inputs();
        for (int i = 0; i < cutoff_pkg::num_creators; i++) begin
            if (taken[i]) begin
                void'(creator_q[i].pop_front());
            end
            taken[i] = 1'b0;
            if (creator_q[i].size() > 0) begin
                creator_tvalid[i] = 1'b1;
                creator_tdata[i] = creator_q[i][0][63:0];
                creator_tlast[i] = creator_q[i][0][64];
            end else begin
                creator_tvalid[i] = 1'b0;
                creator_tdata[i] = '0;
                creator_tlast[i] = 1'b0;
            end
        end
        sched_tready = ($urandom % 4) != 0;
        deps_tready = ($urandom % 4) != 0;
        ack_tready = ($urandom % 2) == 0;
    endtask

    task automatic run_cycle();
        @(negedge clk);
        sample_outputs();
        @(posedge clk);
        #10;
        update_inputs();
    endtask

    function automatic logic all_done();
        logic busy;
        busy = sched_data_q.size() != 0 || deps_data_q.size() != 0 || ack_dest_q.size() != 0;
        for (int i = 0; i < cutoff_pkg::num_creators; i++) begin
            busy = busy || creator_q[i].size() != 0;
        end
        return !busy;
    endfunction

    task automatic apply_record(string line);
        string       kind;
        string       name;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] d;
        int          n;
        n = $sscanf(line, "%s", kind);
        case (kind)
            "T": begin
                n = $sscanf(line, "%s %s", kind, name);
                cur_test = name;
            end
            "W": begin
                n = $sscanf(line, "%s %h %h %h", kind, a, b, d);
                creator_q[a[1:0]].push_back({b[0], d});
            end
            "S": begin
                n = $sscanf(line, "%s %h %h %h", kind, a, b, d);
                sched_tid_q.push_back(a[1:0]);
                sched_last_q.push_back(b[0]);
                sched_data_q.push_back(d);
            end
            "D": begin
                n = $sscanf(line, "%s %h %h", kind, a, b);
                deps_last_q.push_back(a[0]);
                deps_data_q.push_back(b);
            end
            "A": begin
                n = $sscanf(line, "%s %h %h", kind, a, b);
                ack_dest_q.push_back(a[1:0]);
                ack_code_q.push_back(b[7:0]);
            end
            "F": begin
                n = $sscanf(line, "%s %h", kind, a);
                deps_full = a[0];
            end
            "R": begin
                n = $sscanf(line, "%s %h", kind, a);
                release_parent = a;
                release_valid = 1'b1;
                run_cycle();
                release_valid = 1'b0;
                release_parent = '0;
            end
            "G": begin
                while (!all_done()) begin
                    run_cycle();
                end
                repeat (4) run_cycle(); // Catches stray outputs.
            end
            default: begin
                $display("unknown vector record kind %s", kind);
                errors++;
            end
        endcase
    endtask

    initial begin
        int    fd;
        string line;
        string kind;
        void'($urandom(9));
        rstn = 1'b0;
        creator_tvalid = '0;
        creator_tlast = '0;
        for (int i = 0; i < cutoff_pkg::num_creators; i++) begin
            creator_tdata[i] = '0;
        end
        taken = '0;
        deps_full = 1'b0;
        release_valid = 1'b0;
        release_parent = '0;
        sched_tready = 1'b0;
        deps_tready = 1'b0;
        ack_tready = 1'b0;
        fd = $fopen("bench/cutoff_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open bench/cutoff_vectors.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) > 0 && $sscanf(line, "%s", kind) == 1) begin
                    if (kind.substr(0, 0) != "#") begin
                        records.push_back(line);
                    end
                end
            end
            $fclose(fd);
        end
        n_records = records.size();
        repeat (3) @(posedge clk);
        #10;
        rstn = 1'b1;
        foreach (records[r]) begin
            apply_record(records[r]);
        end
        if (!all_done()) begin
            $display("expected outputs or creator words were left over at the end");
            errors++;
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Watchdog, 200 cycles per vector record.
    initial begin
        wait (n_records > 0);
        repeat (n_records * 200) @(posedge clk);
        $display("watchdog expired after %0d cycles", n_records * 200);
        $display("test failed");
        $finish;
    end

endmodule

// ==== bench/cutoff_vectors.txt ====
# T name | W creator last data | S tid last data | D last data | A dest code
# F deps_full | R parent | G wait until all expected outputs are seen (values in hex)
T sched_forward
W 0 0 0000000500000000
W 0 0 aa
W 0 1 1234
S 0 0 0000000500000000
S 0 0 aa
S 0 1 1234
G
T deps_forward
W 3 0 0000000100000002
W 3 0 bb
W 3 1 55
D 0 0000000100000002
D 0 bb
D 1 55
A 3 1
G
T deps_full_final
F 1
W 2 0 0000000200000001
W 2 1 cc
A 2 2
G
F 0
T table_full_reject
W 0 0 0
W 0 1 100
W 0 0 0
W 0 1 101
W 0 0 0
W 0 1 102
W 0 0 0
W 0 1 103
W 0 0 0
W 0 1 104
S 0 0 0
S 0 1 100
S 0 0 0
S 0 1 101
S 0 0 0
S 0 1 102
S 0 0 0
S 0 1 103
A 0 0
G
T release_accept
R 101
W 0 0 0
W 0 1 105
S 0 0 0
S 0 1 105
G
T two_creators
W 1 0 0000000700000000
W 1 0 11
W 1 1 12
W 1 0 0000000800000000
W 1 1 21
W 2 0 0000000900000003
W 2 0 31
W 2 1 32
W 2 0 0000000a00000001
W 2 1 41
S 1 0 0000000700000000
S 1 0 11
S 1 1 12
S 1 0 0000000800000000
S 1 1 21
D 0 0000000900000003
D 0 31
D 1 32
D 0 0000000a00000001
D 1 41
A 2 1
A 2 1
G

// ==== bench/tb_clock.sv ====
// Free-running clock starting low; the period is in ns and must be even.
`timescale 1ns/1ps

module tb_clock #(
    parameter int period = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

endmodule

// ==== common/cutoff_pkg.sv ====
// Widths and header field positions assume a 64-bit word, four creators and a four-entry table.
package cutoff_pkg;

    // Creator side.
    localparam int num_creators = 4;
    localparam int acc_bits = 2;

    typedef logic [acc_bits-1:0] acc_id_t;

    // Stream data word.
    typedef logic [63:0] word_t;

    // Taskwait table geometry.
    localparam int tw_entries = 4;
    localparam int tw_addr_bits = 2;

    typedef logic [tw_addr_bits-1:0] tw_addr_t;

    // Header word fields.
    localparam int seq_id_l = 32; // Zero marks first child.
    localparam int seq_id_h = 63;
    localparam int num_deps_l = 0;
    localparam int num_deps_bits = 8; // Nonzero means deps path.

    // Ack codes in the low byte of the ack word.
    typedef logic [7:0] ack_code_t;

    localparam ack_code_t ack_reject_code = 8'd0;
    localparam ack_code_t ack_ok_code = 8'd1;
    localparam ack_code_t ack_final_code = 8'd2;

endpackage

// ==== cutoff/cutoff_manager.sv ====
// One message in flight; a table hit needs both parent id and creator id, messages need two words.
`timescale 1ns/1ps

module cutoff_manager (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  deps_full,
    input  logic                  in_tvalid,
    output logic                  in_tready,
    input  cutoff_pkg::word_t     in_tdata,
    input  logic                  in_tlast,
    input  cutoff_pkg::acc_id_t   in_tid,
    output logic                  sched_tvalid,
    input  logic                  sched_tready,
    output cutoff_pkg::word_t     sched_tdata,
    output logic                  sched_tlast,
    output cutoff_pkg::acc_id_t   sched_tid,
    output logic                  deps_tvalid,
    input  logic                  deps_tready,
    output cutoff_pkg::word_t     deps_tdata,
    output logic                  deps_tlast,
    output logic                  ack_tvalid,
    input  logic                  ack_tready,
    output cutoff_pkg::word_t     ack_tdata,
    output cutoff_pkg::acc_id_t   ack_tdest,
    output cutoff_pkg::tw_addr_t  tw_addr,
    output logic                  tw_en,
    output logic                  tw_we,
    output cutoff_pkg::acc_id_t   tw_wr_acc,
    output cutoff_pkg::word_t     tw_wr_parent,
    input  logic                  tw_rd_valid,
    input  cutoff_pkg::acc_id_t   tw_rd_acc,
    input  cutoff_pkg::word_t     tw_rd_parent
);

    typedef enum logic [2:0] {
        st_idle,
        st_read_ptid,
        st_search,
        st_create,
        st_buf_full,
        st_buf_empty,
        st_drain,
        st_ack
    } state_t;

    state_t               state;
    cutoff_pkg::acc_id_t  acc_id;
    cutoff_pkg::word_t    parent_id;
    cutoff_pkg::word_t    buf_tdata;
    logic                 buf_tlast;
    logic                 deps_sel;
    logic                 accept;
    logic                 final_mode;
    logic                 free_found;
    cutoff_pkg::tw_addr_t free_addr;
    cutoff_pkg::tw_addr_t rd_addr;    // Entry shown on the read port.
    cutoff_pkg::ack_code_t ack_code;
    logic                 out_valid;
    logic                 out_ready;
    logic                 first_child;
    logic                 has_deps;
    logic                 hit;

    assign first_child = in_tdata[cutoff_pkg::seq_id_h:cutoff_pkg::seq_id_l] == '0;
    assign has_deps = in_tdata[cutoff_pkg::num_deps_l +: cutoff_pkg::num_deps_bits] != '0;
    assign hit = tw_rd_valid && tw_rd_parent == parent_id && tw_rd_acc == acc_id;

    assign out_valid = state == st_buf_full;
    assign out_ready = deps_sel ? deps_tready : sched_tready;

    assign sched_tvalid = out_valid && !deps_sel;
    assign sched_tdata = buf_tdata;
    assign sched_tlast = buf_tlast;
    assign sched_tid = acc_id;
    assign deps_tvalid = out_valid && deps_sel;
    assign deps_tdata = buf_tdata;
    assign deps_tlast = buf_tlast;

    assign ack_code = accept ? cutoff_pkg::ack_ok_code :
                      final_mode ? cutoff_pkg::ack_final_code : cutoff_pkg::ack_reject_code;
    assign ack_tvalid = state == st_ack;
    assign ack_tdata = {56'd0, ack_code};
    assign ack_tdest = acc_id;

    assign tw_en = (state == st_read_ptid && in_tvalid) || state == st_search || state == st_create;
    assign tw_we = state == st_create;
    assign tw_wr_acc = acc_id;
    assign tw_wr_parent = parent_id;

    always_comb begin
        case (state)
            st_idle:      in_tready = in_tvalid;
            st_buf_full:  in_tready = out_ready && !buf_tlast;
            st_buf_empty: in_tready = 1'b1;
            st_drain:     in_tready = 1'b1;
            default:      in_tready = 1'b0; // Parent id is only peeked.
        endcase
    end

    always_ff @(posedge clk) begin
        rd_addr <= tw_addr;
        case (state)
            st_idle: begin
                buf_tdata <= in_tdata;
                buf_tlast <= in_tlast;
                acc_id <= in_tid;
                deps_sel <= has_deps;
                accept <= 1'b0;
                final_mode <= 1'b0;
                free_found <= 1'b0;
                tw_addr <= '0;
                if (in_tvalid) begin
                    if (first_child) begin
                        state <= st_read_ptid;
                    end else if (has_deps && deps_full) begin
                        final_mode <= 1'b1;
                        state <= in_tlast ? st_ack : st_drain;
                    end else begin
                        accept <= 1'b1;
                        state <= st_buf_full;
                    end
                end
            end
            st_read_ptid: begin
                parent_id <= in_tdata;
                if (in_tvalid) begin
                    tw_addr <= tw_addr + 1'b1;
                    state <= st_search;
                end
            end
            st_search: begin
                if (!tw_rd_valid && !free_found) begin
                    free_found <= 1'b1;
                    free_addr <= rd_addr;
                end
                tw_addr <= tw_addr + 1'b1;
                if (hit) begin
                    if (deps_sel && deps_full) begin
                        final_mode <= 1'b1;
                        state <= st_drain;
                    end else begin
                        accept <= 1'b1;
                        state <= st_buf_full;
                    end
                end else if (rd_addr == cutoff_pkg::tw_addr_t'(cutoff_pkg::tw_entries - 1)) begin
                    if (free_found) begin
                        tw_addr <= free_addr;
                        state <= st_create;
                    end else if (!tw_rd_valid) begin
                        tw_addr <= rd_addr;
                        state <= st_create;
                    end else begin
                        state <= st_drain; // Table full, reject.
                    end
                end
            end
            st_create: begin
                if (deps_sel && deps_full) begin
                    final_mode <= 1'b1;
                    state <= st_drain;
                end else begin
                    accept <= 1'b1;
                    state <= st_buf_full;
                end
            end
            st_buf_full: begin
                if (out_ready) begin
                    if (buf_tlast) begin
                        state <= deps_sel ? st_ack : st_idle;
                    end else if (in_tvalid) begin
                        buf_tdata <= in_tdata;
                        buf_tlast <= in_tlast;
                    end else begin
                        state <= st_buf_empty;
                    end
                end
            end
            st_buf_empty: begin
                buf_tdata <= in_tdata;
                buf_tlast <= in_tlast;
                if (in_tvalid) begin
                    state <= st_buf_full;
                end
            end
            st_drain: begin
                if (in_tvalid && in_tlast) begin
                    state <= st_ack;
                end
            end
            st_ack: begin
                if (ack_tready) begin
                    state <= st_idle;
                end
            end
            default: state <= st_idle;
        endcase
        if (!rstn) begin
            state <= st_idle;
            tw_addr <= '0;
        end
    end

    // Parent word stays on the input while the table is searched.
    a_parent_stable: assert property (@(posedge clk) disable iff (!rstn)
        state == st_search || state == st_create |-> in_tvalid && in_tdata == parent_id);

    // A new entry only overwrites one that was free.
    a_write_free: assert property (@(posedge clk) disable iff (!rstn)
        tw_we |=> !tw_rd_valid);

    a_ack_hold: assert property (@(posedge clk) disable iff (!rstn)
        ack_tvalid && !ack_tready |=> ack_tvalid && $stable(ack_tdata) && $stable(ack_tdest));

endmodule

// ==== cutoff/taskwait_table.sv ====
// Read data is valid one cycle after tw_en; a write beats a release of the same entry.
`timescale 1ns/1ps

module taskwait_table (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     tw_en,
    input  logic                     tw_we,
    input  cutoff_pkg::tw_addr_t     tw_addr,
    input  cutoff_pkg::acc_id_t      tw_wr_acc,
    input  cutoff_pkg::word_t        tw_wr_parent,
    output logic                     tw_rd_valid,
    output cutoff_pkg::acc_id_t      tw_rd_acc,
    output cutoff_pkg::word_t        tw_rd_parent,
    input  logic                     release_valid,
    input  cutoff_pkg::word_t        release_parent
);

    logic [cutoff_pkg::tw_entries-1:0] valid;
    cutoff_pkg::acc_id_t               acc_mem [cutoff_pkg::tw_entries];
    cutoff_pkg::word_t                 parent_mem [cutoff_pkg::tw_entries];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid <= '0;
            tw_rd_valid <= 1'b0;
        end else begin
            for (int i = 0; i < cutoff_pkg::tw_entries; i++) begin
                if (release_valid && valid[i] && parent_mem[i] == release_parent) begin
                    valid[i] <= 1'b0;
                end
            end
            if (tw_en) begin
                tw_rd_valid <= valid[tw_addr]; // Old value on a write.
                if (tw_we) begin
                    valid[tw_addr] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tw_en) begin
            tw_rd_acc <= acc_mem[tw_addr];
            tw_rd_parent <= parent_mem[tw_addr];
            if (tw_we) begin
                acc_mem[tw_addr] <= tw_wr_acc;
                parent_mem[tw_addr] <= tw_wr_parent;
            end
        end
    end

endmodule

// ==== files.f ====
common/cutoff_pkg.sv
verilog/creator_arbiter.sv
cutoff/taskwait_table.sv
cutoff/cutoff_manager.sv
verilog/cutoff_top.sv
bench/tb_clock.sv
bench/cutoff_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module cutoff_tb -f files.f
./obj_dir/Vcutoff_tb > sim.log 2>&1 || true
cat sim.log

if grep -qx "test passed" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== verilog/creator_arbiter.sv ====
// Round-robin merge; a grant is held from the first taken word until the tlast word is taken.
`timescale 1ns/1ps

module creator_arbiter (
    input  logic                                 clk,
    input  logic                                 rstn,
    input  logic [cutoff_pkg::num_creators-1:0]  creator_tvalid,
    output logic [cutoff_pkg::num_creators-1:0]  creator_tready,
    input  cutoff_pkg::word_t                    creator_tdata [cutoff_pkg::num_creators],
    input  logic [cutoff_pkg::num_creators-1:0]  creator_tlast,
    output logic                                 in_tvalid,
    input  logic                                 in_tready,
    output cutoff_pkg::word_t                    in_tdata,
    output logic                                 in_tlast,
    output cutoff_pkg::acc_id_t                  in_tid
);

    logic                locked;
    cutoff_pkg::acc_id_t grant_q; // Creator owning the current message.
    cutoff_pkg::acc_id_t ptr;     // First candidate for the next grant.
    cutoff_pkg::acc_id_t pick;
    cutoff_pkg::acc_id_t sel;
    logic                any_req;

    always_comb begin
        cutoff_pkg::acc_id_t idx;
        pick = ptr;
        any_req = 1'b0;
        for (int i = 0; i < cutoff_pkg::num_creators; i++) begin
            idx = ptr + cutoff_pkg::acc_id_t'(i);
            if (!any_req && creator_tvalid[idx]) begin
                pick = idx;
                any_req = 1'b1;
            end
        end
    end

    assign sel = locked ? grant_q : pick;

    assign in_tvalid = locked ? creator_tvalid[grant_q] : any_req;
    assign in_tdata = creator_tdata[sel];
    assign in_tlast = creator_tlast[sel];
    assign in_tid = sel;

    always_comb begin
        creator_tready = '0;
        creator_tready[sel] = in_tready;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            locked <= 1'b0;
            grant_q <= '0;
            ptr <= '0;
        end else if (in_tvalid && in_tready) begin
            if (in_tlast) begin
                locked <= 1'b0;
                ptr <= sel + 1'b1; // Next creator after this one.
            end else begin
                locked <= 1'b1;
                grant_q <= sel;
            end
        end
    end

    // A stalled word of the granted message stays on the output.
    a_grant_held: assert property (@(posedge clk) disable iff (!rstn)
        locked && in_tvalid && !in_tready |=> in_tvalid && in_tid == $past(in_tid)
            && in_tdata == $past(in_tdata) && in_tlast == $past(in_tlast));

endmodule

// ==== verilog/cutoff_top.sv ====
// Ready inputs and deps_full come from outside; release_valid is a one-cycle pulse.
`timescale 1ns/1ps

module cutoff_top (
    input  logic                                 clk,
    input  logic                                 rstn,
    input  logic [cutoff_pkg::num_creators-1:0]  creator_tvalid,
    output logic [cutoff_pkg::num_creators-1:0]  creator_tready,
    input  cutoff_pkg::word_t                    creator_tdata [cutoff_pkg::num_creators],
    input  logic [cutoff_pkg::num_creators-1:0]  creator_tlast,
    input  logic                                 deps_full,
    input  logic                                 release_valid,
    input  cutoff_pkg::word_t                    release_parent,
    output logic                                 sched_tvalid,
    input  logic                                 sched_tready,
    output cutoff_pkg::word_t                    sched_tdata,
    output logic                                 sched_tlast,
    output cutoff_pkg::acc_id_t                  sched_tid,
    output logic                                 deps_tvalid,
    input  logic                                 deps_tready,
    output cutoff_pkg::word_t                    deps_tdata,
    output logic                                 deps_tlast,
    output logic                                 ack_tvalid,
    input  logic                                 ack_tready,
    output cutoff_pkg::word_t                    ack_tdata,
    output cutoff_pkg::acc_id_t                  ack_tdest
);

    // Merged creator stream.
    logic                  in_tvalid;
    logic                  in_tready;
    cutoff_pkg::word_t     in_tdata;
    logic                  in_tlast;
    cutoff_pkg::acc_id_t   in_tid;

    // Table port.
    cutoff_pkg::tw_addr_t  tw_addr;
    logic                  tw_en;
    logic                  tw_we;
    cutoff_pkg::acc_id_t   tw_wr_acc;
    cutoff_pkg::word_t     tw_wr_parent;
    logic                  tw_rd_valid;
    cutoff_pkg::acc_id_t   tw_rd_acc;
    cutoff_pkg::word_t     tw_rd_parent;

    creator_arbiter arbiter_i (.clk, .rstn, .creator_tvalid, .creator_tready, .creator_tdata,
        .creator_tlast, .in_tvalid, .in_tready, .in_tdata, .in_tlast, .in_tid);

    taskwait_table table_i (.clk, .rstn, .tw_en, .tw_we, .tw_addr, .tw_wr_acc, .tw_wr_parent,
        .tw_rd_valid, .tw_rd_acc, .tw_rd_parent, .release_valid, .release_parent);

    cutoff_manager manager_i (.clk, .rstn, .deps_full,
        .in_tvalid, .in_tready, .in_tdata, .in_tlast, .in_tid,
        .sched_tvalid, .sched_tready, .sched_tdata, .sched_tlast, .sched_tid,
        .deps_tvalid, .deps_tready, .deps_tdata, .deps_tlast,
        .ack_tvalid, .ack_tready, .ack_tdata, .ack_tdest,
        .tw_addr, .tw_en, .tw_we, .tw_wr_acc, .tw_wr_parent,
        .tw_rd_valid, .tw_rd_acc, .tw_rd_parent);

endmodule
